// ==== verilog/isp_pkg.sv ====
package isp_pkg;

    // ==========================================================
    // picture geometry and DRAM layout
    // ==========================================================
    localparam int PIX_W        = 8;
    localparam int BEAT_PIX     = 16;
    localparam int DATA_W       = 128;
    localparam int ADDR_W       = 32;
    localparam int BEATS_PER_CH = 64;
    localparam int BURST_BEATS  = 192;

    localparam logic [ADDR_W-1:0] PIC_BASE   = 32'h0001_0000;
    localparam logic [ADDR_W-1:0] PIC_STRIDE = 32'h0000_0C00;

    // frame sum to average
    localparam int AVG_SHIFT = 10;
    localparam int ACC_W     = 18;

    typedef logic [1:0] ratio_t;
    typedef logic [3:0] pic_no_t;

    localparam ratio_t RATIO_QUARTER = 2'd0;
    localparam ratio_t RATIO_HALF    = 2'd1;
    localparam ratio_t RATIO_UNITY   = 2'd2;
    localparam ratio_t RATIO_DOUBLE  = 2'd3;

    typedef enum logic [1:0] {
        CH_RED   = 2'd0,
        CH_GREEN = 2'd1,
        CH_BLUE  = 2'd2
    } channel_t;

    // ==========================================================
    // AXI channel bundles
    // ==========================================================
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic              valid;
    } axi_addr_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
        logic              valid;
    } axi_rdata_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
        logic              valid;
    } axi_wdata_t;

    // scaled beat toward the gray path
    typedef struct packed {
        logic [BEAT_PIX-1:0][PIX_W-1:0] pix;
        channel_t                       ch;
        logic                           last;
        logic                           valid;
    } pix_beat_t;

    // 16 weighted pixels, at most 16 * 127
    typedef struct packed {
        logic [11:0] sum;
        logic        last;
    } gray_sum_t;

endpackage

// ==== verilog/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic     full;
    payload_t data_q;

    // room when empty or when the held item leaves this cycle
    assign in_ready  = ~full | out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

// ==== verilog/dram_request.sv ====
`timescale 1ns/1ps

module dram_request
    import isp_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  pic_no_t   in_pic_no,
    input  ratio_t    in_ratio_mode,
    output axi_addr_t ar,
    input  logic      arready,
    output axi_addr_t aw,
    input  logic      awready,
    input  logic      bvalid,
    output logic      bready,
    output ratio_t    ratio,
    output logic      busy,
    output logic      write_done,
    input  logic      frame_done
);

    logic              accept;
    logic              ar_valid;
    logic              aw_valid;
    logic [ADDR_W-1:0] pic_addr;

    // one job at a time
    assign accept = in_valid & ~busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (frame_done) begin
            busy <= 1'b0;
        end
    end

    // ==========================================================
    // request latch
    // ==========================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            pic_addr <= PIC_BASE + ADDR_W'(in_pic_no) * PIC_STRIDE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ratio <= RATIO_UNITY;
        end else if (accept) begin
            ratio <= in_ratio_mode;
        end
    end

    // read and write bursts share the address, both raised together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid <= 1'b0;
            aw_valid <= 1'b0;
        end else begin
            if (accept) begin
                ar_valid <= 1'b1;
            end else if (ar_valid && arready) begin
                ar_valid <= 1'b0;
            end
            if (accept) begin
                aw_valid <= 1'b1;
            end else if (aw_valid && awready) begin
                aw_valid <= 1'b0;
            end
        end
    end

    // response wait opens once AW is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bready <= 1'b0;
        end else if (aw_valid && awready) begin
            bready <= 1'b1;
        end else if (bvalid) begin
            bready <= 1'b0;
        end
    end

    assign write_done = bvalid & bready;

    assign ar = '{addr: pic_addr, len: 8'(BURST_BEATS - 1), valid: ar_valid};
    assign aw = '{addr: pic_addr, len: 8'(BURST_BEATS - 1), valid: aw_valid};

endmodule

// ==== verilog/exposure_scaler.sv ====
`timescale 1ns/1ps

module exposure_scaler
    import isp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  ratio_t     ratio,
    input  axi_rdata_t r,
    output logic       rready,
    output axi_wdata_t w,
    input  logic       wready,
    output pix_beat_t  beat,
    input  logic       beat_ready
);

    logic [$clog2(BURST_BEATS)-1:0] beat_cnt;
    logic [BEAT_PIX-1:0][PIX_W-1:0] scaled;
    channel_t                       ch;
    logic                           r_fire;
    logic                           w_in_ready;
    logic                           g_in_ready;
    logic                           w_valid;
    logic                           g_valid;
    axi_wdata_t                     w_in;
    axi_wdata_t                     w_q;
    pix_beat_t                      g_in;
    pix_beat_t                      g_q;

    function automatic logic [PIX_W-1:0] scale_pix(input logic [PIX_W-1:0] p, input ratio_t mode);
        case (mode)
            RATIO_QUARTER: return p >> 2;
            RATIO_HALF:    return p >> 1;
            // saturate once the top bit would shift out
            RATIO_DOUBLE:  return p[PIX_W-1] ? '1 : {p[PIX_W-2:0], 1'b0};
            default:       return p;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < BEAT_PIX; i++) begin
            scaled[i] = scale_pix(r.data[i*PIX_W +: PIX_W], ratio);
        end
    end

    // beats arrive as red, green, blue blocks
    always_comb begin
        if (beat_cnt < BEATS_PER_CH) begin
            ch = CH_RED;
        end else if (beat_cnt < 2 * BEATS_PER_CH) begin
            ch = CH_GREEN;
        end else begin
            ch = CH_BLUE;
        end
    end

    // take a beat only when both copies have room
    assign rready = r.valid & w_in_ready & g_in_ready;
    assign r_fire = r.valid & rready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (r_fire) begin
            beat_cnt <= r.last ? '0 : beat_cnt + 1'b1;
        end
    end

    assign w_in = '{data: scaled, last: r.last, valid: 1'b1};
    assign g_in = '{pix: scaled, ch: ch, last: r.last, valid: 1'b1};

    stage_reg #(.payload_t(axi_wdata_t)) w_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (r_fire),
        .in_data   (w_in),
        .in_ready  (w_in_ready),
        .out_valid (w_valid),
        .out_data  (w_q),
        .out_ready (wready)
    );

    stage_reg #(.payload_t(pix_beat_t)) g_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (r_fire),
        .in_data   (g_in),
        .in_ready  (g_in_ready),
        .out_valid (g_valid),
        .out_data  (g_q),
        .out_ready (beat_ready)
    );

    assign w    = '{data: w_q.data, last: w_q.last, valid: w_valid};
    assign beat = '{pix: g_q.pix, ch: g_q.ch, last: g_q.last, valid: g_valid};

endmodule

// ==== verilog/gray_accumulator.sv ====
`timescale 1ns/1ps

module gray_accumulator
    import isp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  pix_beat_t  beat,
    input  logic       write_done,
    output logic       out_valid,
    output logic [7:0] out_data,
    output logic       frame_done
);

    logic [BEAT_PIX-1:0][PIX_W-1:0] weighted;
    logic [7:0][8:0]                lvl1;
    logic [3:0][9:0]                lvl2;
    logic [1:0][10:0]               lvl3;
    gray_sum_t                      sum_in;
    gray_sum_t                      sum_q;
    logic                           sum_valid;
    logic [ACC_W-1:0]               acc;
    logic [ACC_W-1:0]               acc_next;
    logic                           sum_last;
    logic                           last_seen;
    logic                           wr_seen;
    logic                           fire;

    // ==========================================================
    // weighting and adder tree
    // ==========================================================
    // green counts half, red and blue a quarter
    always_comb begin
        for (int i = 0; i < BEAT_PIX; i++) begin
            weighted[i] = (beat.ch == CH_GREEN) ? beat.pix[i] >> 1 : beat.pix[i] >> 2;
        end
        for (int i = 0; i < 8; i++) begin
            lvl1[i] = 9'(weighted[2*i]) + 9'(weighted[2*i+1]);
        end
        for (int i = 0; i < 4; i++) begin
            lvl2[i] = 10'(lvl1[2*i]) + 10'(lvl1[2*i+1]);
        end
        for (int i = 0; i < 2; i++) begin
            lvl3[i] = 11'(lvl2[2*i]) + 11'(lvl2[2*i+1]);
        end
    end

    assign sum_in = '{sum: 12'(lvl3[0]) + 12'(lvl3[1]), last: beat.last};

    // never stalls
    stage_reg #(.payload_t(gray_sum_t)) sum_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (beat.valid),
        .in_data   (sum_in),
        .in_ready  (),
        .out_valid (sum_valid),
        .out_data  (sum_q),
        .out_ready (1'b1)
    );

    // ==========================================================
    // frame accumulator
    // ==========================================================
    assign acc_next = acc + (sum_valid ? ACC_W'(sum_q.sum) : '0);
    assign sum_last = sum_valid & sum_q.last;

    // result waits for both the last sum and the write response
    assign fire       = (last_seen | sum_last) & (wr_seen | write_done);
    assign frame_done = fire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc       <= '0;
            last_seen <= 1'b0;
            wr_seen   <= 1'b0;
        end else if (fire) begin
            acc       <= '0;
            last_seen <= 1'b0;
            wr_seen   <= 1'b0;
        end else begin
            acc <= acc_next;
            if (sum_last) begin
                last_seen <= 1'b1;
            end
            if (write_done) begin
                wr_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= fire;
            out_data  <= fire ? acc_next[AVG_SHIFT +: 8] : '0;
        end
    end

endmodule

// ==== verilog/isp_top.sv ====
`timescale 1ns/1ps

module isp_top
    import isp_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  pic_no_t           in_pic_no,
    input  ratio_t            in_ratio_mode,
    output logic              out_valid,
    output logic [7:0]        out_data,
    // read address
    output logic              arvalid,
    output logic [ADDR_W-1:0] araddr,
    output logic [7:0]        arlen,
    input  logic              arready,
    // read data
    input  logic [DATA_W-1:0] rdata,
    input  logic              rlast,
    input  logic              rvalid,
    output logic              rready,
    // write address
    output logic              awvalid,
    output logic [ADDR_W-1:0] awaddr,
    output logic [7:0]        awlen,
    input  logic              awready,
    // write data
    output logic [DATA_W-1:0] wdata,
    output logic              wlast,
    output logic              wvalid,
    input  logic              wready,
    // write response
    input  logic              bvalid,
    output logic              bready
);

    axi_addr_t  ar;
    axi_addr_t  aw;
    axi_rdata_t r;
    axi_wdata_t w;
    pix_beat_t  beat;
    ratio_t     ratio;
    logic       write_done;
    logic       frame_done;

    assign r = '{data: rdata, last: rlast, valid: rvalid};

    assign arvalid = ar.valid;
    assign araddr  = ar.addr;
    assign arlen   = ar.len;
    assign awvalid = aw.valid;
    assign awaddr  = aw.addr;
    assign awlen   = aw.len;
    assign wvalid  = w.valid;
    assign wdata   = w.data;
    assign wlast   = w.last;

    dram_request dram_request_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pic_no     (in_pic_no),
        .in_ratio_mode (in_ratio_mode),
        .ar            (ar),
        .arready       (arready),
        .aw            (aw),
        .awready       (awready),
        .bvalid        (bvalid),
        .bready        (bready),
        .ratio         (ratio),
        .busy          (),
        .write_done    (write_done),
        .frame_done    (frame_done)
    );

    exposure_scaler exposure_scaler_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ratio      (ratio),
        .r          (r),
        .rready     (rready),
        .w          (w),
        .wready     (wready),
        .beat       (beat),
        .beat_ready (1'b1)
    );

    gray_accumulator gray_accumulator_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat       (beat),
        .write_done (write_done),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .frame_done (frame_done)
    );

endmodule

// ==== verif/isp_props.sv ====
`timescale 1ns/1ps

module isp_props
    import isp_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              arvalid,
    input logic [ADDR_W-1:0] araddr,
    input logic [7:0]        arlen,
    input logic              arready,
    input logic              awvalid,
    input logic [ADDR_W-1:0] awaddr,
    input logic [7:0]        awlen,
    input logic              awready,
    input logic [DATA_W-1:0] wdata,
    input logic              wlast,
    input logic              wvalid,
    input logic              wready,
    input logic              rready,
    input logic              out_valid
);

    // set by any failing property, watched from the testbench
    logic violation = 1'b0;

    // ==========================================================
    // valid and payload hold until ready
    // ==========================================================
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
    else begin
        violation = 1'b1;
        $error("AR valid or payload changed before arready");
    end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
    else begin
        violation = 1'b1;
        $error("AW valid or payload changed before awready");
    end

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
    else begin
        violation = 1'b1;
        $error("W valid or payload changed before wready");
    end

    // result is a single-cycle pulse
    out_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
    else begin
        violation = 1'b1;
        $error("out_valid high two cycles in a row");
    end

    // a stalled W beat blocks the read burst
    r_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |-> !rready)
    else begin
        violation = 1'b1;
        $error("rready high while the W beat is stalled");
    end

endmodule

bind isp_top isp_props props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .arvalid   (arvalid),
    .araddr    (araddr),
    .arlen     (arlen),
    .arready   (arready),
    .awvalid   (awvalid),
    .awaddr    (awaddr),
    .awlen     (awlen),
    .awready   (awready),
    .wdata     (wdata),
    .wlast     (wlast),
    .wvalid    (wvalid),
    .wready    (wready),
    .rready    (rready),
    .out_valid (out_valid)
);

// ==== verif/isp_tb.sv ====
`timescale 1ns/1ps

module isp_tb
    import isp_pkg::*;
#(
    parameter logic [31:0] SEED = 32'ha349e3b0
) ();

    // five frames of 192 beats, random stalls keep one frame under ~1000 cycles
    localparam int MAX_CYCLES = 20000;
    localparam int MEM_WORDS  = 16 * BURST_BEATS;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    pic_no_t           in_pic_no;
    ratio_t            in_ratio_mode;
    logic              out_valid;
    logic [7:0]        out_data;
    logic              arvalid;
    logic [ADDR_W-1:0] araddr;
    logic [7:0]        arlen;
    logic              arready = 1'b0;
    logic [DATA_W-1:0] rdata   = '0;
    logic              rlast   = 1'b0;
    logic              rvalid  = 1'b0;
    logic              rready;
    logic              awvalid;
    logic [ADDR_W-1:0] awaddr;
    logic [7:0]        awlen;
    logic              awready = 1'b0;
    logic [DATA_W-1:0] wdata;
    logic              wlast;
    logic              wvalid;
    logic              wready  = 1'b0;
    logic              bvalid  = 1'b0;
    logic              bready;

    // DRAM contents and the reference copy
    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    logic [DATA_W-1:0] exp_beats [BURST_BEATS];

    integer     seed;
    int         ready_pct = 70;
    int         cycles    = 0;
    string      cur_test  = "reset_values";
    int         rd_pic    = 0;
    int         r_limit   = 0;
    int         r_sent    = 0;
    int         r_acc     = 0;
    int         w_total   = 0;
    int         w_start   = 0;
    int         wl_total  = 0;
    int         aw_total  = 0;
    int         b_sent    = 0;
    int         b_acc     = 0;
    int         ov_total  = 0;
    logic [7:0] out_seen  = '0;

    isp_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==========================================================
    // failure reporting
    // ==========================================================
    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_failure(input string why);
        $display("ERROR %s", why);
        abort_run();
    endtask

    task automatic report_mismatch(input string what, input logic [DATA_W-1:0] expected,
                                   input logic [DATA_W-1:0] actual);
        $display("MISMATCH %s: expected %0h, actual %0h", what, expected, actual);
        abort_run();
    endtask

    // ==========================================================
    // reference model
    // ==========================================================
    function automatic bit roll_percent(input int pct);
        int r;
        r = $unsigned($random(seed)) % 100;
        return r < pct;
    endfunction

    function automatic logic [PIX_W-1:0] expected_pixel(input logic [PIX_W-1:0] p,
                                                        input ratio_t mode);
        int v;
        case (mode)
            RATIO_QUARTER: v = p / 4;
            RATIO_HALF:    v = p / 2;
            RATIO_DOUBLE:  v = (2 * p > 255) ? 255 : 2 * p;
            default:       v = p;
        endcase
        return PIX_W'(v);
    endfunction

    // green weighs a half, red and blue a quarter
    function automatic int gray_share(input int p, input int beat_no);
        return (beat_no / BEATS_PER_CH == 1) ? p / 2 : p / 4;
    endfunction

    task automatic fill_memory();
        logic [DATA_W-1:0] word;
        for (int a = 0; a < MEM_WORDS; a++) begin
            word       = {$random(seed), $random(seed), $random(seed), $random(seed)};
            mem[a]     = word;
            ref_mem[a] = word;
        end
    endtask

    // ==========================================================
    // DRAM model
    // ==========================================================
    always @(negedge clk) begin
        arready = roll_percent(ready_pct);
        awready = roll_percent(ready_pct);
        wready  = roll_percent(ready_pct);
        // a raised rvalid keeps its beat until taken
        if (!(rvalid && r_sent != r_acc)) begin
            if (r_sent < r_limit && roll_percent(ready_pct)) begin
                rdata  = mem[rd_pic * BURST_BEATS + r_sent % BURST_BEATS];
                rlast  = (r_sent % BURST_BEATS) == BURST_BEATS - 1;
                rvalid = 1'b1;
                r_sent++;
            end else begin
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
        end
        // response only after both AW and the last W beat
        if (!(bvalid && b_sent != b_acc)) begin
            if (b_sent < aw_total && b_sent < wl_total && roll_percent(ready_pct)) begin
                bvalid = 1'b1;
                b_sent++;
            end else begin
                bvalid = 1'b0;
            end
        end
    end

    task automatic check_write_beat();
        int idx;
        idx = w_total - w_start;
        assert (idx < BURST_BEATS)
            else report_failure($sformatf("%s: more than 192 W beats", cur_test));
        assert (wdata === exp_beats[idx])
            else report_mismatch($sformatf("%s wdata[%0d]", cur_test, idx), exp_beats[idx], wdata);
        assert (wlast === (idx == BURST_BEATS - 1))
            else report_mismatch($sformatf("%s wlast[%0d]", cur_test, idx),
                                 idx == BURST_BEATS - 1, wlast);
        mem[rd_pic * BURST_BEATS + idx] = wdata;
        if (wlast) begin
            wl_total++;
        end
        w_total++;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            report_failure($sformatf("timeout, run still going after %0d cycles", MAX_CYCLES));
        end
        if (rst_n) begin
            if (arvalid && arready) begin
                rd_pic  = int'((araddr - PIC_BASE) / PIC_STRIDE);
                r_limit += BURST_BEATS;
            end
            if (awvalid && awready) begin
                aw_total++;
            end
            if (rvalid && rready) begin
                r_acc++;
            end
            if (wvalid && wready) begin
                check_write_beat();
            end
            if (bvalid && bready) begin
                b_acc++;
            end
            if (out_valid) begin
                ov_total++;
                out_seen = out_data;
            end
        end
    end

    always @(negedge clk) begin
        if (dut_i.props_i.violation) begin
            report_failure("a protocol assertion in isp_props failed");
        end
    end

    // ==========================================================
    // stimulus
    // ==========================================================
    task automatic check_idle(input string name);
        assert ({arvalid, awvalid, wvalid, rready, bready, out_valid,
                 dut_i.dram_request_i.busy} === 7'b0)
            else report_failure($sformatf("%s: a valid output or busy is high before a request",
                                          name));
        assert (out_data === 8'h00)
            else report_mismatch({name, " out_data"}, 0, out_data);
    endtask

    task automatic run_request(input string name, input pic_no_t pic, input ratio_t mode);
        int                base;
        int                gray;
        int                ov_start;
        logic [7:0]        exp_avg;
        logic [ADDR_W-1:0] exp_addr;
        logic [DATA_W-1:0] word;
        base = int'(pic) * BURST_BEATS;
        gray = 0;
        for (int b = 0; b < BURST_BEATS; b++) begin
            for (int i = 0; i < BEAT_PIX; i++) begin
                word[i*PIX_W +: PIX_W] = expected_pixel(ref_mem[base+b][i*PIX_W +: PIX_W], mode);
                gray += gray_share(int'(word[i*PIX_W +: PIX_W]), b);
            end
            exp_beats[b]     = word;
            ref_mem[base+b]  = word;
        end
        exp_avg  = 8'(gray >> AVG_SHIFT);
        exp_addr = PIC_BASE + ADDR_W'(pic) * PIC_STRIDE;

        @(negedge clk);
        cur_test = name;
        w_start  = w_total;
        ov_start = ov_total;
        assert (!arvalid && !awvalid)
            else report_failure($sformatf("%s: address valid high before in_valid", name));
        in_valid      = 1'b1;
        in_pic_no     = pic;
        in_ratio_mode = mode;
        @(negedge clk);
        in_valid = 1'b0;
        // AR and AW one cycle after the request
        assert (arvalid === 1'b1 && awvalid === 1'b1)
            else report_failure($sformatf("%s: AR and AW not raised one cycle after in_valid",
                                          name));
        assert (araddr === exp_addr) else report_mismatch({name, " araddr"}, exp_addr, araddr);
        assert (awaddr === exp_addr) else report_mismatch({name, " awaddr"}, exp_addr, awaddr);
        assert (arlen === 8'd191) else report_mismatch({name, " arlen"}, 191, arlen);
        assert (awlen === 8'd191) else report_mismatch({name, " awlen"}, 191, awlen);

        while (ov_total == ov_start) begin
            @(negedge clk);
        end
        assert (out_seen === exp_avg) else report_mismatch({name, " out_data"}, exp_avg, out_seen);
        assert (w_total - w_start == BURST_BEATS)
            else report_mismatch({name, " W beat count"}, BURST_BEATS, w_total - w_start);
        repeat (3) @(negedge clk);
        assert (ov_total - ov_start == 1)
            else report_mismatch({name, " out_valid pulses"}, 1, ov_total - ov_start);
        for (int b = 0; b < BURST_BEATS; b++) begin
            assert (mem[base+b] === ref_mem[base+b])
                else report_mismatch($sformatf("%s picture beat %0d", name, b),
                                     ref_mem[base+b], mem[base+b]);
        end
    endtask

    initial begin
        in_valid      = 1'b0;
        in_pic_no     = '0;
        in_ratio_mode = '0;
        rst_n         = 1'b0;
        seed          = SEED;
        fill_memory();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle("reset_values");
        end

        run_request("unity_pic3", 4'd3, RATIO_UNITY);
        run_request("double_pic5", 4'd5, RATIO_DOUBLE);
        // second request reads what the first wrote back
        run_request("quarter_pic7", 4'd7, RATIO_QUARTER);
        run_request("half_pic7", 4'd7, RATIO_HALF);
        // heavier stalls on every channel
        @(posedge clk);
        ready_pct = 35;
        run_request("stalls_pic9", 4'd9, RATIO_DOUBLE);

        if (dut_i.props_i.violation) begin
            report_failure("a protocol assertion in isp_props failed");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
verilog/isp_pkg.sv
verilog/stage_reg.sv
verilog/dram_request.sv
verilog/exposure_scaler.sv
verilog/gray_accumulator.sv
verilog/isp_top.sv
verif/isp_props.sv
verif/isp_tb.sv

// ==== Makefile ====
# Verilator build and run of the ISP testbench

VERILATOR ?= verilator
TOP       ?= isp_tb
SEED      ?= 32'ha349e3b0
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# pass only when the testbench prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) \
		-f $(FILELIST) "-GSEED=$(SEED)"
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^\*\* PASS \*\*$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
